// File: Makefile
VERILATOR ?= verilator
TOP       := ht_tb
FILELIST  := project.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)
LOG       := sim.log
PASS_TEXT := Simulation finished: PASS

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/ht_tb.sv
// hash table testbench
`timescale 1ns/1ps

module ht_tb;

  localparam int          OP_LIMIT    = 200;
  localparam int          SETTLE      = 40;
  localparam logic [31:0] SEED        = 32'hdbcd8881;

  logic        clk;
  logic        rst;
  logic [1:0]  wb_adr;
  logic [31:0] wb_dat_i;
  logic [31:0] wb_dat_o;
  logic        wb_we;
  logic        wb_stb;
  logic        wb_cyc;
  logic        wb_ack;

  // reference model of the stored pairs
  logic [15:0] model_map [logic [15:0]];
  logic [15:0] stored_keys [$];

  int    op_count;
  int    check_count;
  int    error_count;
  int    errors_before;
  string cur_test;

  ht_top i_dut (
    .clk_i    (clk),
    .rst_i    (rst),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_we_i  (wb_we),
    .wb_stb_i (wb_stb),
    .wb_cyc_i (wb_cyc),
    .wb_ack_o (wb_ack)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] result_word(input hash_table_pkg::ht_res_t res,
                                              input logic [15:0] value);
    return {13'd0, res, value};
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] got);
    check_count++;
    assert (got === exp)
    else
    begin
      $display("Fail %s %s expected %h actual %h", cur_test, what, exp, got);
      error_count++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test      = name;
    errors_before = error_count;
  endtask

  task automatic end_test();
    if (error_count == errors_before)
      $display("test %s: ok", cur_test);
    else
      $display("test %s: %0d failed checks", cur_test, error_count - errors_before);
  endtask

  // one classic cycle with stb held until ack
  task automatic bus_op(input logic [1:0] adr, input logic we, input logic [31:0] dat,
                        output logic [31:0] rdata);
    int   waited;
    logic acked;
    waited = 0;
    acked  = 1'b0;
    rdata  = '0;
    op_count++;
    @(posedge clk);
    wb_adr   <= adr;
    wb_dat_i <= dat;
    wb_we    <= we;
    wb_stb   <= 1'b1;
    wb_cyc   <= 1'b1;
    while (!acked && waited < OP_LIMIT)
    begin
      @(negedge clk);
      if (wb_ack)
      begin
        acked = 1'b1;
        rdata = wb_dat_o;
      end
      waited++;
    end
    @(posedge clk);
    wb_stb <= 1'b0;
    wb_cyc <= 1'b0;
    wb_we  <= 1'b0;
    @(negedge clk);
    check_count++;
    assert (acked)
    else
    begin
      $display("%s: no ack within %0d cycles at address %0d", cur_test, OP_LIMIT, adr);
      error_count++;
    end
    check_count++;
    assert (wb_ack === 1'b0)
    else
    begin
      $display("%s: ack stayed high after the cycle ended", cur_test);
      error_count++;
    end
  endtask

  // predict, submit the command, then read back the result word
  task automatic run_cmd(input logic is_search, input logic [15:0] key, input logic [15:0] value);
    hash_table_pkg::ht_res_t exp_res;
    logic [15:0]             exp_value;
    logic [31:0]             rdata;
    if (is_search)
    begin
      if (model_map.exists(key))
      begin
        exp_res   = hash_table_pkg::SEARCH_FOUND;
        exp_value = model_map[key];
      end
      else
      begin
        exp_res   = hash_table_pkg::SEARCH_NOT_FOUND;
        exp_value = '0;
      end
    end
    else
    begin
      exp_value = value;
      if (model_map.exists(key))
      begin
        exp_res        = hash_table_pkg::INSERT_SUCCESS_SAME_KEY;
        model_map[key] = value;
      end
      else if (stored_keys.size() == hash_table_pkg::TABLE_DEPTH)
        exp_res = hash_table_pkg::INSERT_NOT_SUCCESS_TABLE_IS_FULL;
      else
      begin
        exp_res        = hash_table_pkg::INSERT_SUCCESS;
        model_map[key] = value;
        stored_keys.push_back(key);
      end
    end
    bus_op(is_search ? 2'd1 : 2'd0, 1'b1, {key, value}, rdata);
    bus_op(2'd2, 1'b0, 32'd0, rdata);
    check_value($sformatf("key %h", key), result_word(exp_res, exp_value), rdata);
  endtask

  initial
  begin
    logic [15:0] key;
    logic [31:0] rdata;
    int          tries;
    rst         = 1'b1;
    wb_adr      = '0;
    wb_dat_i    = '0;
    wb_we       = 1'b0;
    wb_stb      = 1'b0;
    wb_cyc      = 1'b0;
    op_count    = 0;
    check_count = 0;
    error_count = 0;
    void'($urandom(SEED));
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    // free address store loads during this wait
    repeat (20) @(posedge clk);

    begin_test("reset_search");
    @(negedge clk);
    check_value("ack after reset", 32'd0, {31'd0, wb_ack});
    run_cmd(1'b1, 16'($urandom()), 16'd0);
    bus_op(2'd3, 1'b0, 32'd0, rdata);
    check_value("read of unused address", 32'd0, rdata);
    end_test();

    begin_test("insert_search");
    run_cmd(1'b0, 16'h1234, 16'($urandom()));
    run_cmd(1'b1, 16'h1234, 16'd0);
    end_test();

    // all three hash to bucket 1
    begin_test("chain_three");
    run_cmd(1'b0, 16'h0001, 16'($urandom()));
    run_cmd(1'b0, 16'h0008, 16'($urandom()));
    run_cmd(1'b0, 16'h0040, 16'($urandom()));
    run_cmd(1'b1, 16'h0001, 16'd0);
    run_cmd(1'b1, 16'h0008, 16'd0);
    run_cmd(1'b1, 16'h0040, 16'd0);
    end_test();

    begin_test("same_key");
    run_cmd(1'b0, 16'h0008, 16'($urandom()));
    run_cmd(1'b0, 16'h0040, 16'($urandom()));
    run_cmd(1'b1, 16'h0008, 16'd0);
    run_cmd(1'b1, 16'h0040, 16'd0);
    end_test();

    // absent keys that still land in bucket 1
    begin_test("absent_in_chain");
    run_cmd(1'b1, 16'h0201, 16'd0);
    run_cmd(1'b1, 16'h8e01, 16'd0);
    end_test();

    begin_test("fill_table");
    tries = 0;
    while (stored_keys.size() < hash_table_pkg::TABLE_DEPTH && tries < 64)
    begin
      run_cmd(1'b0, 16'($urandom()), 16'($urandom()));
      tries++;
    end
    // the full case below needs every entry in use
    check_value("stored key count", hash_table_pkg::TABLE_DEPTH, stored_keys.size());
    key = 16'($urandom());
    while (model_map.exists(key))
      key = 16'($urandom());
    run_cmd(1'b0, key, 16'($urandom()));
    run_cmd(1'b1, key, 16'd0);
    run_cmd(1'b0, stored_keys[0], 16'($urandom()));
    for (int i = 0; i < stored_keys.size(); i++)
      run_cmd(1'b1, stored_keys[i], 16'd0);
    end_test();

    $display("checks run: %0d, failed: %0d", check_count, error_count);
    if (error_count == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  // budget grows with every bus operation issued
  initial
  begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= OP_LIMIT * (op_count + 1) + SETTLE)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("watchdog expired after %0d cycles with %0d bus operations", cycles, op_count);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: logic/hash_table_pkg.sv
// hash table shared definitions
package hash_table_pkg;

  localparam int KEY_WIDTH        = 16;
  localparam int VALUE_WIDTH      = 16;
  localparam int BUCKET_WIDTH     = 3;
  localparam int BUCKET_COUNT     = 2 ** BUCKET_WIDTH;
  localparam int TABLE_ADDR_WIDTH = 4;
  localparam int TABLE_DEPTH      = 2 ** TABLE_ADDR_WIDTH;
  localparam int RAM_LATENCY      = 2;

  typedef enum logic {
    CMD_INSERT,
    CMD_SEARCH
  } ht_cmd_t;

  typedef enum logic [2:0] {
    INSERT_SUCCESS                   = 3'd0,
    INSERT_SUCCESS_SAME_KEY          = 3'd1,
    INSERT_NOT_SUCCESS_TABLE_IS_FULL = 3'd2,
    SEARCH_FOUND                     = 3'd3,
    SEARCH_NOT_FOUND                 = 3'd4
  } ht_res_t;

  typedef struct packed {
    ht_cmd_t                cmd;
    logic [KEY_WIDTH-1:0]   key;
    logic [VALUE_WIDTH-1:0] value;
  } ht_cmd_req_t;

  typedef struct packed {
    ht_cmd_t                     cmd;
    logic [KEY_WIDTH-1:0]        key;
    logic [VALUE_WIDTH-1:0]      value;
    logic [BUCKET_WIDTH-1:0]     bucket;
    logic [TABLE_ADDR_WIDTH-1:0] head_ptr;
    logic                        head_ptr_val;
  } ht_data_task_t;

  // one chain entry as stored in the data RAM
  typedef struct packed {
    logic [KEY_WIDTH-1:0]        key;
    logic [VALUE_WIDTH-1:0]      value;
    logic [TABLE_ADDR_WIDTH-1:0] next_ptr;
    logic                        next_ptr_val;
  } ram_data_t;

  typedef struct packed {
    ht_cmd_t                cmd;
    logic [KEY_WIDTH-1:0]   key;
    logic [VALUE_WIDTH-1:0] value;
    ht_res_t                res;
  } ht_result_t;

  typedef struct packed {
    logic [BUCKET_WIDTH-1:0]     bucket;
    logic [TABLE_ADDR_WIDTH-1:0] ptr;
    logic                        en;
  } ht_head_wr_t;

  typedef struct packed {
    logic [TABLE_ADDR_WIDTH-1:0] addr;
    logic                        en;
  } ht_ram_rd_t;

  typedef struct packed {
    logic [TABLE_ADDR_WIDTH-1:0] addr;
    ram_data_t                   data;
    logic                        en;
  } ht_ram_wr_t;

endpackage

// File: logic/ht_data_insert.sv
// insert engine
`timescale 1ns/1ps

module ht_data_insert (
  input  logic                                        clk_i,
  input  logic                                        rst_i,
  input  hash_table_pkg::ht_data_task_t               task_i,
  input  logic                                        task_valid_i,
  output logic                                        task_ready_o,
  output hash_table_pkg::ht_ram_rd_t                  rd_o,
  input  hash_table_pkg::ram_data_t                   rd_data_i,
  input  logic                                        rd_data_val_i,
  output hash_table_pkg::ht_ram_wr_t                  wr_o,
  input  logic [hash_table_pkg::TABLE_ADDR_WIDTH-1:0] empty_addr_i,
  input  logic                                        empty_addr_val_i,
  output logic                                        empty_addr_rd_ack_o,
  output hash_table_pkg::ht_head_wr_t                 head_wr_o,
  output hash_table_pkg::ht_result_t                  result_o,
  output logic                                        result_valid_o
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_WALK,
    S_KEY_MATCH,
    S_FULL,
    S_HEAD_WR,
    S_NEW_WR,
    S_TAIL_WR,
    S_TAIL_LINK
  } state_t;

  state_t                                      state_q;
  state_t                                      state_d;
  hash_table_pkg::ht_data_task_t               task_q;
  hash_table_pkg::ram_data_t                   cur_q;
  logic [hash_table_pkg::TABLE_ADDR_WIDTH-1:0] rd_addr_q;
  logic                                        rd_go_q;
  logic                                        accept;
  logic                                        key_match;
  logic                                        at_tail;
  logic                                        step;

  assign task_ready_o = (state_q == S_IDLE);
  assign accept       = task_ready_o && task_valid_i;
  assign key_match    = (rd_data_i.key == task_q.key);
  assign at_tail      = !rd_data_i.next_ptr_val;
  // follow next_ptr to the following entry
  assign step         = (state_q == S_WALK) && rd_data_val_i && !key_match && !at_tail;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      S_IDLE:
        if (task_valid_i)
        begin
          if (task_i.head_ptr_val)
            state_d = S_WALK;
          else
            state_d = empty_addr_val_i ? S_HEAD_WR : S_FULL;
        end
      S_WALK:
        if (rd_data_val_i)
        begin
          if (key_match)
            state_d = S_KEY_MATCH;
          else if (at_tail)
            state_d = empty_addr_val_i ? S_TAIL_WR : S_FULL;
        end
      S_HEAD_WR: state_d = S_NEW_WR;
      S_TAIL_WR: state_d = S_TAIL_LINK;
      default:   state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q <= S_IDLE;
      rd_go_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      rd_go_q <= (accept && task_i.head_ptr_val) || step;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      task_q    <= task_i;
      rd_addr_q <= task_i.head_ptr;
    end
    else if (step)
      rd_addr_q <= rd_data_i.next_ptr;
    // last entry read, kept for rewrite and tail link
    if ((state_q == S_WALK) && rd_data_val_i)
      cur_q <= rd_data_i;
  end

  assign rd_o.addr = rd_addr_q;
  assign rd_o.en   = rd_go_q;

  always_comb
  begin
    wr_o.addr = rd_addr_q;
    wr_o.data = cur_q;
    wr_o.en   = 1'b0;
    case (state_q)
      S_KEY_MATCH:
      begin
        wr_o.data.value = task_q.value;
        wr_o.en         = 1'b1;
      end
      S_NEW_WR, S_TAIL_WR:
      begin
        wr_o.addr              = empty_addr_i;
        wr_o.data.key          = task_q.key;
        wr_o.data.value        = task_q.value;
        wr_o.data.next_ptr     = '0;
        wr_o.data.next_ptr_val = 1'b0;
        wr_o.en                = 1'b1;
      end
      S_TAIL_LINK:
      begin
        wr_o.data.next_ptr     = empty_addr_i;
        wr_o.data.next_ptr_val = 1'b1;
        wr_o.en                = 1'b1;
      end
      default:
      begin
        wr_o.en = 1'b0;
      end
    endcase
  end

  assign head_wr_o.bucket = task_q.bucket;
  assign head_wr_o.ptr    = empty_addr_i;
  assign head_wr_o.en     = (state_q == S_HEAD_WR);

  // free address is used up once the entry is linked
  assign empty_addr_rd_ack_o = (state_q == S_NEW_WR) || (state_q == S_TAIL_LINK);

  always_comb
  begin
    result_o.cmd   = task_q.cmd;
    result_o.key   = task_q.key;
    result_o.value = task_q.value;
    case (state_q)
      S_KEY_MATCH: result_o.res = hash_table_pkg::INSERT_SUCCESS_SAME_KEY;
      S_FULL:      result_o.res = hash_table_pkg::INSERT_NOT_SUCCESS_TABLE_IS_FULL;
      default:     result_o.res = hash_table_pkg::INSERT_SUCCESS;
    endcase
  end

  assign result_valid_o = (state_q == S_KEY_MATCH) || (state_q == S_FULL) ||
                          (state_q == S_NEW_WR) || (state_q == S_TAIL_LINK);

endmodule

// File: logic/ht_data_ram.sv
// chain entry memory
`timescale 1ns/1ps

module ht_data_ram (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  hash_table_pkg::ht_ram_rd_t ins_rd_i,
  input  hash_table_pkg::ht_ram_rd_t srch_rd_i,
  input  hash_table_pkg::ht_ram_wr_t wr_i,
  output hash_table_pkg::ram_data_t  rd_data_o,
  output logic                       rd_data_val_o
);

  hash_table_pkg::ram_data_t                   mem_q [hash_table_pkg::TABLE_DEPTH];
  hash_table_pkg::ram_data_t                   data_pipe_q [hash_table_pkg::RAM_LATENCY];
  logic [hash_table_pkg::RAM_LATENCY-1:0]      val_pipe_q;
  logic                                        rd_en;
  logic [hash_table_pkg::TABLE_ADDR_WIDTH-1:0] rd_addr;

  // only one engine reads at a time
  assign rd_en   = ins_rd_i.en || srch_rd_i.en;
  assign rd_addr = ins_rd_i.en ? ins_rd_i.addr : srch_rd_i.addr;

  always_ff @(posedge clk_i)
  begin
    if (wr_i.en)
      mem_q[wr_i.addr] <= wr_i.data;
    data_pipe_q[0] <= mem_q[rd_addr];
    for (int i = 1; i < hash_table_pkg::RAM_LATENCY; i++)
      data_pipe_q[i] <= data_pipe_q[i-1];
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      val_pipe_q <= '0;
    else
    begin
      val_pipe_q[0] <= rd_en;
      for (int i = 1; i < hash_table_pkg::RAM_LATENCY; i++)
        val_pipe_q[i] <= val_pipe_q[i-1];
    end
  end

  assign rd_data_o     = data_pipe_q[hash_table_pkg::RAM_LATENCY-1];
  assign rd_data_val_o = val_pipe_q[hash_table_pkg::RAM_LATENCY-1];

endmodule

// File: logic/ht_data_search.sv
// search engine
`timescale 1ns/1ps

module ht_data_search (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  hash_table_pkg::ht_data_task_t task_i,
  input  logic                          task_valid_i,
  output logic                          task_ready_o,
  output hash_table_pkg::ht_ram_rd_t    rd_o,
  input  hash_table_pkg::ram_data_t     rd_data_i,
  input  logic                          rd_data_val_i,
  output hash_table_pkg::ht_result_t    result_o,
  output logic                          result_valid_o
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_WALK,
    S_DONE
  } state_t;

  state_t                                      state_q;
  state_t                                      state_d;
  hash_table_pkg::ht_data_task_t               task_q;
  logic [hash_table_pkg::TABLE_ADDR_WIDTH-1:0] rd_addr_q;
  logic [hash_table_pkg::VALUE_WIDTH-1:0]      value_q;
  logic                                        found_q;
  logic                                        rd_go_q;
  logic                                        accept;
  logic                                        key_match;
  logic                                        step;

  assign task_ready_o = (state_q == S_IDLE);
  assign accept       = task_ready_o && task_valid_i;
  assign key_match    = (rd_data_i.key == task_q.key);
  assign step = (state_q == S_WALK) && rd_data_val_i && !key_match && rd_data_i.next_ptr_val;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      S_IDLE:
        if (task_valid_i)
          state_d = task_i.head_ptr_val ? S_WALK : S_DONE;
      S_WALK:
        if (rd_data_val_i && !step)
          state_d = S_DONE;
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q <= S_IDLE;
      rd_go_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      rd_go_q <= (accept && task_i.head_ptr_val) || step;
    end
  end

  // miss reports value 0
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      task_q    <= task_i;
      rd_addr_q <= task_i.head_ptr;
      found_q   <= 1'b0;
      value_q   <= '0;
    end
    else if (step)
      rd_addr_q <= rd_data_i.next_ptr;
    else if ((state_q == S_WALK) && rd_data_val_i && key_match)
    begin
      found_q <= 1'b1;
      value_q <= rd_data_i.value;
    end
  end

  assign rd_o.addr = rd_addr_q;
  assign rd_o.en   = rd_go_q;

  assign result_o.cmd   = task_q.cmd;
  assign result_o.key   = task_q.key;
  assign result_o.value = value_q;
  assign result_o.res   = found_q ? hash_table_pkg::SEARCH_FOUND :
                                    hash_table_pkg::SEARCH_NOT_FOUND;
  assign result_valid_o = (state_q == S_DONE);

endmodule

// File: logic/ht_empty_ptr_store.sv
// free entry address FIFO
`timescale 1ns/1ps

module ht_empty_ptr_store (
  input  logic                                        clk_i,
  input  logic                                        rst_i,
  output logic [hash_table_pkg::TABLE_ADDR_WIDTH-1:0] empty_addr_o,
  output logic                                        empty_addr_val_o,
  input  logic                                        rd_ack_i
);

  logic [hash_table_pkg::TABLE_ADDR_WIDTH-1:0] fifo_q [hash_table_pkg::TABLE_DEPTH];
  logic [hash_table_pkg::TABLE_ADDR_WIDTH:0]   wr_ptr_q;
  logic [hash_table_pkg::TABLE_ADDR_WIDTH:0]   rd_ptr_q;
  logic                                        init_busy;

  // write pointer doubles as the init counter, top bit marks done
  assign init_busy        = !wr_ptr_q[hash_table_pkg::TABLE_ADDR_WIDTH];
  assign empty_addr_o     = fifo_q[rd_ptr_q[hash_table_pkg::TABLE_ADDR_WIDTH-1:0]];
  assign empty_addr_val_o = !init_busy && (rd_ptr_q != wr_ptr_q);

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end
    else
    begin
      if (init_busy)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (rd_ack_i && empty_addr_val_o)
        rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  // addresses go in ascending order
  always_ff @(posedge clk_i)
  begin
    if (init_busy)
      fifo_q[wr_ptr_q[hash_table_pkg::TABLE_ADDR_WIDTH-1:0]] <=
        wr_ptr_q[hash_table_pkg::TABLE_ADDR_WIDTH-1:0];
  end

endmodule

// File: logic/ht_head_lookup.sv
// bucket hash and head table
`timescale 1ns/1ps

module ht_head_lookup (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  hash_table_pkg::ht_cmd_req_t   req_i,
  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  input  hash_table_pkg::ht_head_wr_t   head_wr_i,
  output hash_table_pkg::ht_data_task_t ins_task_o,
  output logic                          ins_valid_o,
  input  logic                          ins_ready_i,
  output hash_table_pkg::ht_data_task_t srch_task_o,
  output logic                          srch_valid_o,
  input  logic                          srch_ready_i
);

  logic [hash_table_pkg::TABLE_ADDR_WIDTH-1:0] head_ptr_q [hash_table_pkg::BUCKET_COUNT];
  logic [hash_table_pkg::BUCKET_COUNT-1:0]     head_val_q;
  logic [hash_table_pkg::BUCKET_WIDTH-1:0]     bucket;
  hash_table_pkg::ht_data_task_t               task_q;
  logic                                        task_val_q;
  logic                                        is_insert;

  // fold the low nine key bits
  assign bucket      = req_i.key[2:0] ^ req_i.key[5:3] ^ req_i.key[8:6];
  assign req_ready_o = !task_val_q;
  assign is_insert   = (task_q.cmd == hash_table_pkg::CMD_INSERT);

  assign ins_task_o   = task_q;
  assign srch_task_o  = task_q;
  assign ins_valid_o  = task_val_q && is_insert;
  assign srch_valid_o = task_val_q && !is_insert;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      head_val_q <= '0;
      task_val_q <= 1'b0;
    end
    else
    begin
      if (head_wr_i.en)
        head_val_q[head_wr_i.bucket] <= 1'b1;
      if (req_valid_i && req_ready_o)
        task_val_q <= 1'b1;
      else if ((ins_valid_o && ins_ready_i) || (srch_valid_o && srch_ready_i))
        task_val_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (head_wr_i.en)
      head_ptr_q[head_wr_i.bucket] <= head_wr_i.ptr;
    if (req_valid_i && req_ready_o)
    begin
      task_q.cmd          <= req_i.cmd;
      task_q.key          <= req_i.key;
      task_q.value        <= req_i.value;
      task_q.bucket       <= bucket;
      task_q.head_ptr     <= head_ptr_q[bucket];
      task_q.head_ptr_val <= head_val_q[bucket];
    end
  end

endmodule

// File: logic/ht_top.sv
// hash table top level
`timescale 1ns/1ps

module ht_top (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic [1:0]  wb_adr_i,
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  input  logic        wb_we_i,
  input  logic        wb_stb_i,
  input  logic        wb_cyc_i,
  output logic        wb_ack_o
);

  hash_table_pkg::ht_cmd_req_t                 req;
  logic                                        req_valid;
  logic                                        req_ready;
  hash_table_pkg::ht_data_task_t               ins_task;
  logic                                        ins_valid;
  logic                                        ins_ready;
  hash_table_pkg::ht_data_task_t               srch_task;
  logic                                        srch_valid;
  logic                                        srch_ready;
  hash_table_pkg::ht_head_wr_t                 head_wr;
  hash_table_pkg::ht_ram_rd_t                  ins_rd;
  hash_table_pkg::ht_ram_rd_t                  srch_rd;
  hash_table_pkg::ht_ram_wr_t                  ram_wr;
  hash_table_pkg::ram_data_t                   rd_data;
  logic                                        rd_data_val;
  logic [hash_table_pkg::TABLE_ADDR_WIDTH-1:0] empty_addr;
  logic                                        empty_addr_val;
  logic                                        empty_addr_ack;
  hash_table_pkg::ht_result_t                  ins_result;
  logic                                        ins_result_valid;
  hash_table_pkg::ht_result_t                  srch_result;
  logic                                        srch_result_valid;
  hash_table_pkg::ht_result_t                  result;
  logic                                        result_valid;

  // one task at a time, so at most one engine reports
  assign result       = ins_result_valid ? ins_result : srch_result;
  assign result_valid = ins_result_valid || srch_result_valid;

  ht_wb_port i_port (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .wb_adr_i       (wb_adr_i),
    .wb_dat_i       (wb_dat_i),
    .wb_dat_o       (wb_dat_o),
    .wb_we_i        (wb_we_i),
    .wb_stb_i       (wb_stb_i),
    .wb_cyc_i       (wb_cyc_i),
    .wb_ack_o       (wb_ack_o),
    .req_o          (req),
    .req_valid_o    (req_valid),
    .req_ready_i    (req_ready),
    .result_i       (result),
    .result_valid_i (result_valid)
  );

  ht_head_lookup i_lookup (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (req),
    .req_valid_i  (req_valid),
    .req_ready_o  (req_ready),
    .head_wr_i    (head_wr),
    .ins_task_o   (ins_task),
    .ins_valid_o  (ins_valid),
    .ins_ready_i  (ins_ready),
    .srch_task_o  (srch_task),
    .srch_valid_o (srch_valid),
    .srch_ready_i (srch_ready)
  );

  ht_empty_ptr_store i_free (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .empty_addr_o     (empty_addr),
    .empty_addr_val_o (empty_addr_val),
    .rd_ack_i         (empty_addr_ack)
  );

  ht_data_ram i_ram (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .ins_rd_i      (ins_rd),
    .srch_rd_i     (srch_rd),
    .wr_i          (ram_wr),
    .rd_data_o     (rd_data),
    .rd_data_val_o (rd_data_val)
  );

  ht_data_insert i_insert (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .task_i              (ins_task),
    .task_valid_i        (ins_valid),
    .task_ready_o        (ins_ready),
    .rd_o                (ins_rd),
    .rd_data_i           (rd_data),
    .rd_data_val_i       (rd_data_val),
    .wr_o                (ram_wr),
    .empty_addr_i        (empty_addr),
    .empty_addr_val_i    (empty_addr_val),
    .empty_addr_rd_ack_o (empty_addr_ack),
    .head_wr_o           (head_wr),
    .result_o            (ins_result),
    .result_valid_o      (ins_result_valid)
  );

  ht_data_search i_search (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .task_i         (srch_task),
    .task_valid_i   (srch_valid),
    .task_ready_o   (srch_ready),
    .rd_o           (srch_rd),
    .rd_data_i      (rd_data),
    .rd_data_val_i  (rd_data_val),
    .result_o       (srch_result),
    .result_valid_o (srch_result_valid)
  );

endmodule

// File: logic/ht_wb_port.sv
// wishbone command port
`timescale 1ns/1ps

module ht_wb_port (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic [1:0]                  wb_adr_i,
  input  logic [31:0]                 wb_dat_i,
  output logic [31:0]                 wb_dat_o,
  input  logic                        wb_we_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_cyc_i,
  output logic                        wb_ack_o,
  output hash_table_pkg::ht_cmd_req_t req_o,
  output logic                        req_valid_o,
  input  logic                        req_ready_i,
  input  hash_table_pkg::ht_result_t  result_i,
  input  logic                        result_valid_i
);

  logic                       bus_cycle;
  logic                       cmd_wr;
  logic                       res_rd;
  logic                       other_acc;
  logic                       issue;
  logic                       pending_q;
  logic                       wr_ack_q;
  logic                       rd_ack_q;
  hash_table_pkg::ht_result_t last_q;

  assign bus_cycle = wb_stb_i && wb_cyc_i;
  // addresses 0 and 1 carry commands
  assign cmd_wr    = bus_cycle && wb_we_i && !wb_adr_i[1];
  assign res_rd    = bus_cycle && !wb_we_i && (wb_adr_i == 2'd2);
  assign other_acc = bus_cycle && !cmd_wr && !res_rd;
  // a held stb must not start a second task
  assign issue     = cmd_wr && !pending_q && !wr_ack_q;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      req_valid_o <= 1'b0;
      pending_q   <= 1'b0;
      wr_ack_q    <= 1'b0;
      rd_ack_q    <= 1'b0;
    end
    else
    begin
      wr_ack_q <= result_valid_i;
      rd_ack_q <= res_rd && !rd_ack_q;
      if (req_valid_o && req_ready_i)
        req_valid_o <= 1'b0;
      else if (issue)
      begin
        req_valid_o <= 1'b1;
        pending_q   <= 1'b1;
      end
      if (result_valid_i)
        pending_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (issue)
    begin
      req_o.cmd   <= wb_adr_i[0] ? hash_table_pkg::CMD_SEARCH : hash_table_pkg::CMD_INSERT;
      req_o.key   <= wb_dat_i[31:16];
      req_o.value <= wb_dat_i[15:0];
    end
    if (result_valid_i)
      last_q <= result_i;
  end

  assign wb_dat_o = res_rd ? {13'd0, last_q.res, last_q.value} : 32'd0;
  assign wb_ack_o = wr_ack_q || rd_ack_q || other_acc;

endmodule

// File: project.f
logic/hash_table_pkg.sv
logic/ht_wb_port.sv
logic/ht_head_lookup.sv
logic/ht_empty_ptr_store.sv
logic/ht_data_ram.sv
logic/ht_data_insert.sv
logic/ht_data_search.sv
logic/ht_top.sv
bench/ht_tb.sv
